//--- source/dma_pkg.sv
package dma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////////////////////////

  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 16;
  localparam int TILE_W = 4;

  // One bus or data word
  typedef logic [WORD_W-1:0] word_t;
  // Byte address on the local bus
  typedef logic [ADDR_W-1:0] addr_t;
  // Word count, zero is not a legal length
  typedef logic [LEN_W-1:0]  len_t;
  // Destination tile on the NoC
  typedef logic [TILE_W-1:0] tile_t;

  //////////////////////////////////////////////////////////////////////
  // Descriptor, bus request and flit
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    tile_t dest;
    addr_t laddr;
    len_t  words;
  } dma_desc_t;

  // Address phase of the read master
  // burst_end high ends the burst after this beat
  typedef struct packed {
    logic  sel;
    logic  mastlock;
    logic  burst_end;
    addr_t addr;
  } bus_req_t;

  typedef enum logic [1:0] {
    head = 2'd0,
    data = 2'd1
  } flit_kind_e;

  // Head payload is dest, twelve zero bits, then word count
  typedef struct packed {
    flit_kind_e kind;
    logic       last;
    word_t      payload;
  } flit_t;

endpackage

//--- source/dma_req_ctrl.sv
`timescale 1ns/1ps

module dma_req_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  dma_pkg::dma_desc_t desc,
  input  logic               desc_valid,
  output logic               desc_ready,
  output logic               start,
  output dma_pkg::dma_desc_t cur_desc,
  input  logic               pkt_done,
  output logic               done
);

  // Idle waits for a descriptor, busy covers bus read and packet
  typedef enum logic {
    st_idle = 1'b0,
    st_busy = 1'b1
  } state_e;

  state_e state_q;
  logic   accept;

  //////////////////////////////////////////////////////////////////////
  // Handshake toward the descriptor source
  //////////////////////////////////////////////////////////////////////

  // Only one transfer in flight
  assign desc_ready = (state_q == st_idle);
  assign accept     = desc_valid & desc_ready;

  // Completion is the packetizer's pulse, seen only while busy
  assign done = pkt_done & (state_q == st_busy);

  //////////////////////////////////////////////////////////////////////
  // State and start pulse
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      start   <= 1'b0;
    end else begin
      // Single cycle pulse right after acceptance
      start <= accept;
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q <= st_busy;
          end
        end
        st_busy: begin
          // Back to idle as the last flit is reported
          if (pkt_done) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Held stable for the whole transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_desc <= desc;
    end
  end

endmodule

//--- source/dma_initiator.sv
`timescale 1ns/1ps

module dma_initiator (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  dma_pkg::addr_t    laddr,
  input  dma_pkg::len_t     words,
  output dma_pkg::bus_req_t bus_req,
  input  logic              hready,
  input  dma_pkg::word_t    hrdata,
  output logic              rd_valid,
  output dma_pkg::word_t    rd_data,
  input  logic              rd_ready
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_data = 2'd1,
    st_wait = 2'd2
  } state_e;

  state_e        state_q;
  state_e        state_d;
  dma_pkg::len_t count_q;
  dma_pkg::len_t count_d;
  logic          last_beat;
  logic          push;
  logic          pop;
  logic          store_ready;

  // One-hot fill level, bit 0 empty up to bit 3 with three held
  logic [3:0]     pos_q;
  dma_pkg::word_t store_q [0:2];

  //////////////////////////////////////////////////////////////////////
  // Three-entry store
  //////////////////////////////////////////////////////////////////////

  // Entry 0 is the head of the store
  assign rd_valid = ~pos_q[0];
  assign rd_data  = store_q[0];
  assign pop      = rd_ready & ~pos_q[0];

  // Below high-water, so one more beat plus termination still fits
  assign store_ready = ~|pos_q[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos_q <= 4'b0001;
    end else if (push && !pop) begin
      pos_q <= pos_q << 1;
    end else if (pop && !push) begin
      pos_q <= pos_q >> 1;
    end
  end

  // New word lands one slot lower when a pop shifts the same cycle
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (push && (pop ? pos_q[i+1] : pos_q[i])) begin
        store_q[i] <= hrdata;
      end else if (pop) begin
        store_q[i] <= store_q[i+1];
      end
    end
    if (push && (pop ? pos_q[3] : pos_q[2])) begin
      store_q[2] <= hrdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Burst read master
  //////////////////////////////////////////////////////////////////////

  assign last_beat = (count_q == words - 1'b1);

  // Address advances one word per completed beat
  assign bus_req.addr      = laddr + (dma_pkg::addr_t'(count_q) << 2);
  assign bus_req.sel       = (state_q == st_data);
  assign bus_req.mastlock  = (state_q == st_data);
  // Terminate on the last word or when the store hits high-water
  assign bus_req.burst_end = (state_q == st_data) & (last_beat | ~store_ready);

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    push    = 1'b0;
    case (state_q)
      st_idle: begin
        count_d = '0;
        if (start) begin
          state_d = st_data;
        end
      end
      st_data: begin
        if (hready) begin
          push    = 1'b1;
          count_d = count_q + 1'b1;
          if (last_beat) begin
            state_d = st_idle;
          end else if (!store_ready) begin
            // Pause until an entry drains
            state_d = st_wait;
          end
        end
      end
      st_wait: begin
        if (store_ready) begin
          state_d = st_data;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

endmodule

//--- source/dma_noc_packetizer.sv
`timescale 1ns/1ps

module dma_noc_packetizer #(
  parameter int NOC_CREDITS = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  dma_pkg::tile_t dest,
  input  dma_pkg::len_t  words,
  input  logic           rd_valid,
  input  dma_pkg::word_t rd_data,
  output logic           rd_ready,
  output dma_pkg::flit_t flit,
  output logic           flit_valid,
  input  logic           credit,
  output logic           pkt_done
);

  localparam int CRED_W = $clog2(NOC_CREDITS + 1);

  typedef enum logic [1:0] {
    ph_idle = 2'd0,
    ph_head = 2'd1,
    ph_data = 2'd2
  } phase_e;

  phase_e              phase_q;
  dma_pkg::len_t       data_cnt_q;
  logic [CRED_W-1:0]   cred_cnt;
  logic                has_credit;
  logic                last_data;

  //////////////////////////////////////////////////////////////////////
  // Flit output
  //////////////////////////////////////////////////////////////////////

  assign has_credit = (cred_cnt != '0);
  assign last_data  = (data_cnt_q == words - 1'b1);

  // Data moves only when the store has a word and a credit is held
  assign rd_ready   = (phase_q == ph_data) & rd_valid & has_credit;
  assign flit_valid = ((phase_q == ph_head) & has_credit) | rd_ready;

  always_comb begin
    if (phase_q == ph_head) begin
      flit.kind    = dma_pkg::head;
      flit.last    = 1'b0;
      flit.payload = {dest, 12'd0, words};
    end else begin
      flit.kind    = dma_pkg::data;
      flit.last    = last_data;
      flit.payload = rd_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credits, phase and completion
  //////////////////////////////////////////////////////////////////////

  // Send and return may both happen in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      cred_cnt <= CRED_W'(NOC_CREDITS);
    end else begin
      cred_cnt <= cred_cnt - CRED_W'(flit_valid) + CRED_W'(credit);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q    <= ph_idle;
      data_cnt_q <= '0;
      pkt_done   <= 1'b0;
    end else begin
      pkt_done <= rd_ready & last_data;
      case (phase_q)
        ph_idle: begin
          data_cnt_q <= '0;
          if (start) phase_q <= ph_head;
        end
        ph_head: begin
          if (has_credit) phase_q <= ph_data;
        end
        ph_data: begin
          if (rd_ready) begin
            data_cnt_q <= data_cnt_q + 1'b1;
            // Packet complete after the final data flit
            if (last_data) phase_q <= ph_idle;
          end
        end
        default: phase_q <= ph_idle;
      endcase
    end
  end

endmodule

//--- source/dma_read_top.sv
`timescale 1ns/1ps

module dma_read_top #(
  parameter int NOC_CREDITS = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  dma_pkg::dma_desc_t desc,
  input  logic               desc_valid,
  output logic               desc_ready,
  output logic               done,
  output dma_pkg::bus_req_t  bus_req,
  input  logic               hready,
  input  dma_pkg::word_t     hrdata,
  output dma_pkg::flit_t     flit,
  output logic               flit_valid,
  input  logic               credit
);

  // Controller to both datapath blocks
  logic               start;
  dma_pkg::dma_desc_t cur_desc;
  logic               pkt_done;

  // Store output toward the packetizer
  logic               rd_valid;
  dma_pkg::word_t     rd_data;
  logic               rd_ready;

  dma_req_ctrl req_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .desc       (desc),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .start      (start),
    .cur_desc   (cur_desc),
    .pkt_done   (pkt_done),
    .done       (done)
  );

  dma_initiator initiator_i (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .laddr    (cur_desc.laddr),
    .words    (cur_desc.words),
    .bus_req  (bus_req),
    .hready   (hready),
    .hrdata   (hrdata),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .rd_ready (rd_ready)
  );

  dma_noc_packetizer #(
    .NOC_CREDITS (NOC_CREDITS)
  ) packetizer_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .dest       (cur_desc.dest),
    .words      (cur_desc.words),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .rd_ready   (rd_ready),
    .flit       (flit),
    .flit_valid (flit_valid),
    .credit     (credit),
    .pkt_done   (pkt_done)
  );

endmodule

//--- verif/dma_bus_mem.sv
`timescale 1ns/1ps

module dma_bus_mem (
  input  logic              clk,
  input  dma_pkg::bus_req_t bus_req,
  output logic              hready,
  output dma_pkg::word_t    hrdata
);

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  // Combinational from address, each byte address has its own word
  assign hrdata = (bus_req.addr * 32'h9e3779b1) ^ 32'h5a5a5a5a;

  //////////////////////////////////////////////////////////////////////
  // Wait states
  //////////////////////////////////////////////////////////////////////

  // Ready about 70 percent of cycles, changed on the falling edge
  initial begin
    hready = 1'b0;
    forever begin
      @(negedge clk);
      hready = (($urandom % 100) < 70);
    end
  end

endmodule

//--- verif/dma_read_asserts.sv
`timescale 1ns/1ps

module dma_read_asserts #(
  parameter int NOC_CREDITS = 4
) (
  input logic              clk,
  input logic              rst,
  input dma_pkg::bus_req_t bus_req,
  input logic              hready,
  input logic              flit_valid,
  input logic              credit,
  input logic              desc_valid,
  input logic              desc_ready,
  input logic              done
);

  localparam int CRED_W = $clog2(NOC_CREDITS + 1);

  logic [CRED_W-1:0] cred_shadow;
  logic              busy;

  // Credits seen from the network port
  always_ff @(posedge clk) begin
    if (rst) begin
      cred_shadow <= CRED_W'(NOC_CREDITS);
    end else begin
      cred_shadow <= cred_shadow - CRED_W'(flit_valid) + CRED_W'(credit);
    end
  end

  // Transfer runs from acceptance up to done
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (desc_valid && desc_ready) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Protocol rules
  //////////////////////////////////////////////////////////////////////

  flit_needs_credit: assert property (
    @(posedge clk) disable iff (rst) flit_valid |-> (cred_shadow != '0)
  ) else $error("flit_valid high with the credit counter at zero");

  // Wait state keeps the address phase
  addr_held: assert property (
    @(posedge clk) disable iff (rst)
      (bus_req.sel && !hready) |=> (bus_req.sel && $stable(bus_req.addr))
  ) else $error("bus_req.addr changed during a wait state");

  ready_low_when_busy: assert property (
    @(posedge clk) disable iff (rst) busy |-> !desc_ready
  ) else $error("desc_ready high while a transfer is in progress");

endmodule

bind dma_read_top dma_read_asserts #(
  .NOC_CREDITS (NOC_CREDITS)
) read_asserts_i (
  .clk        (clk),
  .rst        (rst),
  .bus_req    (bus_req),
  .hready     (hready),
  .flit_valid (flit_valid),
  .credit     (credit),
  .desc_valid (desc_valid),
  .desc_ready (desc_ready),
  .done       (done)
);

//--- verif/tb_dma_read.sv
`timescale 1ns/1ps

module tb_dma_read;

  localparam int NOC_CREDITS = 4;
  localparam int RAND_DESCS  = 20;

  logic               clk = 1'b0;
  logic               rst;
  dma_pkg::dma_desc_t desc;
  logic               desc_valid;
  logic               desc_ready;
  logic               done;
  dma_pkg::bus_req_t  bus_req;
  logic               hready;
  dma_pkg::word_t     hrdata;
  dma_pkg::flit_t     flit;
  logic               flit_valid;
  logic               credit = 1'b0;

  // Expected flits and beat addresses, oldest first
  dma_pkg::flit_t     exp_q [$];
  dma_pkg::addr_t     addr_q [$];
  // Set for the last beat of each transfer
  bit                 end_q [$];
  // Cycle at which each consumed credit comes back
  int                 return_q [$];
  int                 cyc = 0;
  int                 in_flight = 0;
  // Words held in the store, beats in minus data flits out
  int                 store_level = 0;
  int                 flit_count = 0;
  int                 beat_count = 0;
  int                 done_count = 0;
  int                 limit_cycles = 0;
  logic               hold_credits = 1'b0;
  logic               xfer_busy = 1'b0;
  logic               stall_seen = 1'b0;
  dma_pkg::addr_t     stall_addr;
  dma_pkg::dma_desc_t rand_descs [RAND_DESCS];

  dma_read_top #(
    .NOC_CREDITS (NOC_CREDITS)
  ) dma_read_top_i (
    .clk        (clk),
    .rst        (rst),
    .desc       (desc),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .done       (done),
    .bus_req    (bus_req),
    .hready     (hready),
    .hrdata     (hrdata),
    .flit       (flit),
    .flit_valid (flit_valid),
    .credit     (credit)
  );

  dma_bus_mem bus_mem_i (
    .clk     (clk),
    .bus_req (bus_req),
    .hready  (hready),
    .hrdata  (hrdata)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic dma_pkg::word_t mem_word(input dma_pkg::addr_t a);
    return (a * 32'h9e3779b1) ^ 32'h5a5a5a5a;
  endfunction

  // Byte address of word n of a transfer
  function automatic dma_pkg::addr_t word_addr(input dma_pkg::dma_desc_t d, input int n);
    return d.laddr + dma_pkg::addr_t'(4 * n);
  endfunction

  // Flit k of a packet, k zero is the head
  function automatic dma_pkg::flit_t expected_flit(input dma_pkg::dma_desc_t d, input int k);
    dma_pkg::flit_t f;
    f = '0;
    if (k == 0) begin
      // Dest on top, word count at the bottom, zeros between
      f.kind           = dma_pkg::head;
      f.payload[31:28] = d.dest;
      f.payload[15:0]  = d.words;
    end else begin
      f.kind    = dma_pkg::data;
      f.last    = (k == int'(d.words));
      f.payload = mem_word(word_addr(d, k - 1));
    end
    return f;
  endfunction

  task automatic load_expected(input dma_pkg::dma_desc_t d);
    for (int k = 0; k <= int'(d.words); k++) begin
      exp_q.push_back(expected_flit(d, k));
      if (k > 0) begin
        addr_q.push_back(word_addr(d, k - 1));
        end_q.push_back(k == int'(d.words));
      end
    end
  endtask

  // Random dest and word-aligned start address
  function automatic dma_pkg::dma_desc_t make_desc(input int n);
    dma_pkg::dma_desc_t d;
    d.dest  = dma_pkg::tile_t'($urandom % 16);
    d.laddr = dma_pkg::addr_t'($urandom & 32'hffff_fffc);
    d.words = dma_pkg::len_t'(n);
    return d;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("At %0t: %s", $time, why);
    stop_run();
  endtask

  task automatic compare_flit(input dma_pkg::flit_t exp_f, input dma_pkg::flit_t act_f);
    if (act_f !== exp_f) begin
      $write("[FAIL] %0t flit expected kind=%0d last=%0b payload=%h",
             $time, exp_f.kind, exp_f.last, exp_f.payload);
      $display(" actual kind=%0d last=%0b payload=%h",
               act_f.kind, act_f.last, act_f.payload);
      stop_run();
    end
  endtask

  task automatic compare_bus_addr(input dma_pkg::addr_t exp_a, input dma_pkg::addr_t act_a);
    if (act_a !== exp_a) begin
      $display("[FAIL] %0t bus_req.addr expected %h actual %h", $time, exp_a, act_a);
      stop_run();
    end
  endtask

  task automatic compare_done_count(input int exp_n, input int act_n);
    if (act_n != exp_n) begin
      $display("[FAIL] %0t done count expected %0d actual %0d", $time, exp_n, act_n);
      stop_run();
    end
  endtask

  task automatic compare_level(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  // Sampled on the rising edge, pre-edge values
  always @(posedge clk) begin
    int delay;
    if (!rst) begin
      if (credit) begin
        in_flight--;
      end
      if (flit_valid) begin
        flit_count++;
        in_flight++;
        delay = int'($urandom % 7);
        return_q.push_back(cyc + delay);
        if (exp_q.size() == 0) begin
          abort_run("Flit sent while no flit was expected");
        end else begin
          compare_flit(exp_q.pop_front(), flit);
        end
      end
      if (in_flight > NOC_CREDITS) begin
        abort_run("More credits in flight than NOC_CREDITS");
      end
      if (bus_req.sel && hready) begin
        beat_count++;
        if (addr_q.size() == 0) begin
          abort_run("Bus beat completed while no beat was expected");
        end else begin
          compare_bus_addr(addr_q.pop_front(), bus_req.addr);
          // Burst ends on the last word or with two words already held
          compare_level("bus_req.burst_end", end_q.pop_front() || (store_level >= 2),
                        bus_req.burst_end);
        end
      end
      // Store fill after this edge
      if (bus_req.sel && hready) begin
        store_level++;
      end
      if (flit_valid && flit.kind == dma_pkg::data) begin
        store_level--;
      end
      // Wait state to be held in the next cycle
      stall_seen = bus_req.sel && !hready;
      stall_addr = bus_req.addr;
      if (done) begin
        done_count++;
      end
      if (desc_valid && desc_ready) begin
        xfer_busy = 1'b1;
      end else if (done) begin
        xfer_busy = 1'b0;
      end
    end
    cyc <= cyc + 1;
  end

  // Protocol rules, seen half a cycle before the next edge
  always @(negedge clk) begin
    if (flit_valid && in_flight >= NOC_CREDITS) begin
      abort_run("flit_valid high while no credit is held");
    end else if (stall_seen && !(bus_req.sel && bus_req.addr == stall_addr)) begin
      abort_run("Bus address phase changed during a wait state");
    end else if (xfer_busy && desc_ready) begin
      abort_run("desc_ready high while a transfer is in progress");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Credit return, at most one per cycle
  always @(negedge clk) begin
    if (!hold_credits && return_q.size() > 0 && return_q[0] <= cyc) begin
      credit = 1'b1;
      void'(return_q.pop_front());
    end else begin
      credit = 1'b0;
    end
  end

  // Called on a falling edge, returns on a falling edge
  task automatic send_desc(input dma_pkg::dma_desc_t d);
    load_expected(d);
    desc       = d;
    desc_valid = 1'b1;
    while (!desc_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    desc_valid = 1'b0;
  endtask

  task automatic wait_done(input int target);
    wait (done_count >= target);
    repeat (4) @(negedge clk);
    compare_done_count(target, done_count);
    if (exp_q.size() != 0 || addr_q.size() != 0) begin
      abort_run("Transfer finished with flits or beats still expected");
    end
  endtask

  initial begin
    int                 total;
    int                 mark;
    int                 base;
    dma_pkg::dma_desc_t d_one;
    dma_pkg::dma_desc_t d_long;
    dma_pkg::dma_desc_t d_held;
    void'($urandom(32'h6bb1));
    rst        = 1'b1;
    desc       = '0;
    desc_valid = 1'b0;
    d_one      = make_desc(1);
    d_long     = make_desc(37);
    d_held     = make_desc(48);
    total      = 1 + 37 + 48;
    for (int i = 0; i < RAND_DESCS; i++) begin
      rand_descs[i] = make_desc(int'($urandom % 64) + 1);
      total += int'(rand_descs[i].words);
    end
    // Data flits plus one head per packet
    limit_cycles = (total + 3 + RAND_DESCS) * 40 + 1000;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Quiet after reset
    repeat (20) begin
      @(negedge clk);
      compare_level("bus_req.sel", 1'b0, bus_req.sel);
      compare_level("bus_req.mastlock", 1'b0, bus_req.mastlock);
      compare_level("flit_valid", 1'b0, flit_valid);
      compare_level("done", 1'b0, done);
      compare_level("desc_ready", 1'b1, desc_ready);
    end

    send_desc(d_one);
    wait_done(1);
    send_desc(d_long);
    wait_done(2);

    // Credits withheld in mid packet
    base = flit_count;
    send_desc(d_held);
    wait (flit_count >= base + 10);
    @(negedge clk);
    hold_credits <= 1'b1;
    repeat (50) @(negedge clk);
    mark = beat_count;
    repeat (150) @(negedge clk);
    if (beat_count != mark) begin
      abort_run("Bus kept issuing beats while credits were withheld");
    end
    hold_credits <= 1'b0;
    wait_done(3);

    // Back to back random packets
    for (int i = 0; i < RAND_DESCS; i++) begin
      send_desc(rand_descs[i]);
    end
    wait_done(3 + RAND_DESCS);

    if (exp_q.size() == 0 && addr_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("Flits or bus beats were never seen");
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    abort_run("Run stalled, watchdog limit reached before all transfers completed");
  end

endmodule

//--- verilog.f
source/dma_pkg.sv
source/dma_req_ctrl.sv
source/dma_initiator.sv
source/dma_noc_packetizer.sv
source/dma_read_top.sv
verif/dma_bus_mem.sv
verif/dma_read_asserts.sv
verif/tb_dma_read.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA read path testbench with Verilator

LOG=sim.log
BIN=obj_dir/tb_dma_read_sim

verilator --binary --timing --assert -j 0 \
  --top-module tb_dma_read -f verilog.f -o tb_dma_read_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./$BIN > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
